//--- filelist.f
+incdir+rtl
+incdir+sim
rtl/isa_pkg.sv
rtl/ctrl_pkg.sv
rtl/inst_decoder.sv
rtl/control_fsm.sv
rtl/datapath.sv
rtl/program_counter.sv
rtl/cpu.sv
sim/cpu_tb.sv

//--- sim/cpu_ref_model.svh
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

localparam int STEP_LIMIT = 4096; // a program that runs longer than this never halts.

addr_t exp_addr_q[$];
word_t exp_data_q[$];
logic  exp_n;
logic  exp_v;
logic  exp_z;
logic  exp_halt;
int    prog_len;

// MOV immediate, branch and HLT share this layout.
function automatic word_t imm_form(opcode_e opc, logic [1:0] op, logic [2:0] field,
                                   logic [7:0] imm8);
    return {opc, op, field, imm8};
endfunction

function automatic word_t reg_form(opcode_e opc, logic [1:0] op, reg_idx_t rn, reg_idx_t rd,
                                   shift_e sh, reg_idx_t rm);
    return {opc, op, rn, rd, sh, rm};
endfunction

function automatic word_t mem_form(opcode_e opc, reg_idx_t rd, reg_idx_t rn, logic [4:0] imm5);
    return {opc, 2'b00, rn, rd, imm5};
endfunction

function automatic void emit(word_t w);
    image[prog_len] = w;
    prog_len++;
endfunction

function automatic void start_image();
    for (int i = 0; i < MEM_WORDS; i++) begin
        image[i] = {7'h5a, addr_t'(i)}; // every word differs, so a wrong address shows.
    end
    prog_len = 0;
endfunction

function automatic word_t shift_b(word_t b, shift_e sh);
    case (sh)
        SH_LSL1: return b << 1;
        SH_LSR1: return b >> 1;
        SH_ASR1: return $signed(b) >>> 1;
        default: return b;
    endcase
endfunction

// Runs the image one instruction at a time and returns how many were executed.
function automatic int ref_run();
    word_t dmem [MEM_WORDS];
    word_t r [`CPU_REG_COUNT];
    word_t ir;
    word_t a;
    word_t b;
    word_t d;
    addr_t pc;
    addr_t ea;
    logic  taken;
    int    steps;
    int    sdiff;
    dmem = image;
    r = '{default: '0};
    pc = '0;
    steps = 0;
    {exp_n, exp_v, exp_z, exp_halt} = '0;
    exp_addr_q.delete();
    exp_data_q.delete();
    while (!exp_halt && steps < STEP_LIMIT) begin
        ir = dmem[pc];
        pc = pc + 1'b1; // a branch offset counts from the next word.
        steps++;
        a  = r[ir[10:8]];
        b  = shift_b(r[ir[2:0]], shift_e'(ir[4:3]));
        d  = a - b;
        ea = addr_t'(a + {{11{ir[4]}}, ir[4:0]});
        case (ir[10:8])
            COND_AL: taken = 1'b1;
            COND_EQ: taken = exp_z;
            COND_NE: taken = !exp_z;
            COND_LT: taken = (exp_n != exp_v);
            COND_LE: taken = (exp_n != exp_v) || exp_z;
            default: taken = 1'b0;
        endcase
        case ({ir[15:13], ir[12:11]})
            {OPC_MOV, MOV_IMM}: r[ir[10:8]] = {{8{ir[7]}}, ir[7:0]};
            {OPC_MOV, MOV_REG}: r[ir[7:5]] = b;
            {OPC_ALU, ALU_ADD}: r[ir[7:5]] = a + b;
            {OPC_ALU, ALU_AND}: r[ir[7:5]] = a & b;
            {OPC_ALU, ALU_MVN}: r[ir[7:5]] = ~b;
            {OPC_ALU, ALU_CMP}: begin
                sdiff = int'($signed(a)) - int'($signed(b));
                exp_n = d[15];
                exp_z = (d == '0);
                exp_v = (sdiff > 32767) || (sdiff < -32768); // the true difference is too wide.
            end
            {OPC_LDR, 2'b00}: r[ir[7:5]] = dmem[ea];
            {OPC_STR, 2'b00}: begin
                dmem[ea] = r[ir[7:5]];
                exp_addr_q.push_back(ea);
                exp_data_q.push_back(r[ir[7:5]]);
            end
            {OPC_BRANCH, 2'b00}: begin
                if (taken) begin
                    pc = pc + addr_t'({{8{ir[7]}}, ir[7:0]});
                end
            end
            default: exp_halt = 1'b1; // HLT and every undefined encoding stop here.
        endcase
    end
    return steps;
endfunction

`endif

//--- sim/cpu_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_consts.svh"

module cpu_tb
    import isa_pkg::*, ctrl_pkg::*;
();

    localparam int MEM_WORDS  = 1 << `CPU_ADDR_W;
    localparam int CLK_PERIOD = 20;
    localparam int MARGIN     = 20; // reset, first fetch and the quiet cycles after halt.

    logic     clk = 1'b0;
    logic     rst_n = 1'b0;
    word_t    in = '0;
    word_t    out;
    logic     n_flag;
    logic     v_flag;
    logic     z_flag;
    mem_cmd_e mem_cmd;
    addr_t    mem_addr;
    logic     halt;

    word_t mem   [MEM_WORDS];
    word_t image [MEM_WORDS];
    addr_t wr_addr_q[$];
    word_t wr_data_q[$];

    time deadline = 1000 * CLK_PERIOD;
    int  test_count;
    int  fail_count;
    int  check_count;
    int  error_count;

    `include "cpu_ref_model.svh"

    cpu cpu_inst (
        .clk(clk), .rst_n(rst_n), .in(in), .out(out), .N(n_flag), .V(v_flag), .Z(z_flag),
        .mem_cmd(mem_cmd), .mem_addr(mem_addr), .halt(halt)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // The memory takes a fresh copy of the image while reset is held.
    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= image[i];
            end
            wr_addr_q.delete();
            wr_data_q.delete();
        end else if (mem_cmd == MEM_READ) begin
            in <= mem[mem_addr]; // read data shows up one cycle after the command.
        end else if (mem_cmd == MEM_WRITE) begin
            mem[mem_addr] <= out;
            wr_addr_q.push_back(mem_addr);
            wr_data_q.push_back(out);
        end
    end

    initial begin
        while ($time <= deadline) begin
            @(posedge clk);
        end
        $display("timeout at %0t: the program did not halt in the time it needs", $time);
        $display("** FAIL **");
        $finish;
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic run_test(input string name);
        int steps;
        int errors_before;
        int writes_at_halt;
        int i;
        errors_before = error_count;
        steps = ref_run();
        deadline = $time + (steps * 11 + MARGIN) * CLK_PERIOD; // STR is the longest at 11 cycles.
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        while (mem_cmd != MEM_READ) begin
            @(negedge clk);
        end
        check_addr("mem_addr", mem_addr, '0); // the first fetch comes from address 0.
        check_flag("halt", halt, 1'b0);
        while (!halt) begin
            @(negedge clk);
        end
        writes_at_halt = wr_addr_q.size();
        repeat (4) @(negedge clk);
        if (wr_addr_q.size() != writes_at_halt) begin
            error_count++;
            $display("test %s: memory was written after the DUT halted", name);
        end
        check_flag("halt", halt, exp_halt);
        check_flag("N", n_flag, exp_n);
        check_flag("V", v_flag, exp_v);
        check_flag("Z", z_flag, exp_z);
        if (wr_addr_q.size() != exp_addr_q.size()) begin
            error_count++;
            $display("test %s: DUT made %0d memory writes where %0d were expected",
                     name, wr_addr_q.size(), exp_addr_q.size());
        end
        for (i = 0; i < wr_addr_q.size() && i < exp_addr_q.size(); i++) begin
            check_addr($sformatf("mem_addr of write %0d", i), wr_addr_q[i], exp_addr_q[i]);
            check_word($sformatf("out of write %0d", i), wr_data_q[i], exp_data_q[i]);
        end
        test_count++;
        if (error_count == errors_before) begin
            $display("test %-14s passed, %0d instructions", name, steps);
        end else begin
            fail_count++;
            $display("test %-14s failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    task automatic alu_test();
        start_image();
        image[100] = word_t'($urandom);
        image[101] = word_t'($urandom);
        emit(imm_form(OPC_MOV, MOV_IMM, 3'd0, 8'd100)); // r0 is the base of the data area.
        emit(mem_form(OPC_LDR, 3'd1, 3'd0, 5'd0));
        emit(mem_form(OPC_LDR, 3'd2, 3'd0, 5'd1));
        emit(imm_form(OPC_MOV, MOV_IMM, 3'd3, 8'($urandom)));
        emit(mem_form(OPC_STR, 3'd3, 3'd0, 5'd2));
        for (int sh = 0; sh < 4; sh++) begin
            emit(reg_form(OPC_MOV, MOV_REG, 3'd0, 3'd4, shift_e'(2'(sh)), 3'd1));
            emit(mem_form(OPC_STR, 3'd4, 3'd0, 5'(3 + sh)));
        end
        emit(reg_form(OPC_ALU, ALU_ADD, 3'd1, 3'd5, shift_e'(2'($urandom)), 3'd2));
        emit(mem_form(OPC_STR, 3'd5, 3'd0, 5'd7));
        emit(reg_form(OPC_ALU, ALU_AND, 3'd1, 3'd6, shift_e'(2'($urandom)), 3'd2));
        emit(mem_form(OPC_STR, 3'd6, 3'd0, 5'd8));
        emit(reg_form(OPC_ALU, ALU_MVN, 3'd0, 3'd7, shift_e'(2'($urandom)), 3'd2));
        emit(mem_form(OPC_STR, 3'd7, 3'd0, 5'd9));
        emit(imm_form(OPC_HALT, 2'b00, 3'd0, 8'd0));
        run_test("mov_alu");
    endtask

    // The store that executes tells which way the branch went.
    task automatic branch_test(input cond_e c, input word_t x, input word_t y, input string name);
        start_image();
        image[100] = x;
        image[101] = y;
        emit(imm_form(OPC_MOV, MOV_IMM, 3'd0, 8'd100));
        emit(mem_form(OPC_LDR, 3'd1, 3'd0, 5'd0));
        emit(mem_form(OPC_LDR, 3'd2, 3'd0, 5'd1));
        emit(imm_form(OPC_MOV, MOV_IMM, 3'd3, 8'h11));
        emit(imm_form(OPC_MOV, MOV_IMM, 3'd4, 8'h22));
        emit(reg_form(OPC_ALU, ALU_CMP, 3'd1, 3'd0, SH_NONE, 3'd2));
        emit(imm_form(OPC_BRANCH, 2'b00, c, 8'd2));
        emit(mem_form(OPC_STR, 3'd3, 3'd0, 5'd2));
        emit(imm_form(OPC_HALT, 2'b00, 3'd0, 8'd0));
        emit(mem_form(OPC_STR, 3'd4, 3'd0, 5'd3));
        emit(imm_form(OPC_HALT, 2'b00, 3'd0, 8'd0));
        run_test(name);
    endtask

    task automatic load_store_test();
        start_image();
        for (int k = 84; k < 116; k++) begin
            image[k] = word_t'($urandom); // every word r0 plus imm5 can reach.
        end
        emit(imm_form(OPC_MOV, MOV_IMM, 3'd0, 8'd100));
        emit(imm_form(OPC_MOV, MOV_IMM, 3'd5, 8'd120));
        for (int k = 1; k < 5; k++) begin
            emit(mem_form(OPC_LDR, reg_idx_t'(k), 3'd0, 5'($urandom)));
            emit(mem_form(OPC_STR, reg_idx_t'(k), 3'd5, 5'($urandom)));
        end
        emit(imm_form(OPC_HALT, 2'b00, 3'd0, 8'd0));
        run_test("ldr_str");
    endtask

    task automatic halt_test(input word_t stop, input string name);
        start_image();
        emit(imm_form(OPC_MOV, MOV_IMM, 3'd0, 8'd100));
        emit(imm_form(OPC_MOV, MOV_IMM, 3'd1, 8'($urandom)));
        emit(mem_form(OPC_STR, 3'd1, 3'd0, 5'd0));
        emit(stop);
        emit(mem_form(OPC_STR, 3'd1, 3'd0, 5'd1)); // must never execute.
        emit(mem_form(OPC_STR, 3'd1, 3'd0, 5'd2));
        run_test(name);
    endtask

    initial begin
        word_t lo;
        word_t hi;
        void'($urandom(32'hf1a2));
        repeat (4) alu_test();
        lo = word_t'($urandom % 1000);
        hi = lo + 16'd1 + word_t'($urandom % 1000);
        branch_test(COND_AL, word_t'($urandom), word_t'($urandom), "cmp_random");
        branch_test(COND_LT, 16'h8000, 16'h0001, "cmp_ovf_neg");
        branch_test(COND_LE, 16'h7fff, 16'hffff, "cmp_ovf_pos");
        branch_test(COND_EQ, lo, lo, "beq_taken");
        branch_test(COND_EQ, hi, lo, "beq_not");
        branch_test(COND_NE, hi, lo, "bne_taken");
        branch_test(COND_NE, lo, lo, "bne_not");
        branch_test(COND_LT, lo, hi, "blt_taken");
        branch_test(COND_LT, hi, lo, "blt_not");
        branch_test(COND_LE, lo, lo, "ble_taken");
        branch_test(COND_LE, lo, hi, "ble_less");
        branch_test(COND_LE, hi, lo, "ble_not");
        repeat (3) load_store_test();
        halt_test(imm_form(OPC_HALT, 2'b00, 3'd0, 8'd0), "hlt");
        halt_test(16'h0000, "undef_opcode");
        halt_test(reg_form(OPC_MOV, 2'b01, 3'd0, 3'd0, SH_NONE, 3'd0), "undef_mov");
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 test_count, fail_count, check_count, error_count);
        if (error_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/cpu.sv
`timescale 1ns/1ns
`default_nettype none

module cpu
    import isa_pkg::*, ctrl_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    input  wire word_t in,
    output word_t      out,
    output logic       N,
    output logic       V,
    output logic       Z,
    output mem_cmd_e   mem_cmd,
    output addr_t      mem_addr,
    output logic       halt
);

    opcode_e    opcode;
    logic [1:0] op;
    alu_op_e    alu_op;
    shift_e     shift;
    cond_e      cond;
    reg_idx_t   reg_num;
    word_t      sximm5;
    word_t      sximm8;
    wb_sel_e    wb_sel;
    reg_sel_e   reg_sel;
    logic       write;
    logic       load_a;
    logic       load_b;
    logic       load_c;
    logic       load_s;
    logic       asel;
    logic       bsel;
    logic       load_ir;
    logic       load_pc;
    logic       load_addr;
    logic       addr_sel;

    inst_decoder u_decoder (
        .clk(clk), .rst_n(rst_n), .in(in), .load_ir(load_ir), .reg_sel(reg_sel),
        .opcode(opcode), .op(op), .alu_op(alu_op), .shift(shift), .cond(cond),
        .reg_num(reg_num), .sximm5(sximm5), .sximm8(sximm8)
    );

    control_fsm u_ctrl (
        .clk(clk), .rst_n(rst_n), .opcode(opcode), .op(op),
        .write(write), .load_a(load_a), .load_b(load_b), .load_c(load_c),
        .load_s(load_s), .asel(asel), .bsel(bsel), .wb_sel(wb_sel), .reg_sel(reg_sel),
        .load_ir(load_ir), .load_pc(load_pc), .load_addr(load_addr),
        .addr_sel(addr_sel), .mem_cmd(mem_cmd), .halt(halt)
    );

    datapath u_dp (
        .clk(clk), .rst_n(rst_n), .mdata(in), .sximm5(sximm5), .sximm8(sximm8),
        .reg_num(reg_num), .write(write), .wb_sel(wb_sel), .load_a(load_a),
        .load_b(load_b), .load_c(load_c), .load_s(load_s), .asel(asel), .bsel(bsel),
        .shift(shift), .alu_op(alu_op), .c_out(out), .n_flag(N), .v_flag(V), .z_flag(Z)
    );

    program_counter u_pc (
        .clk(clk), .rst_n(rst_n), .load_pc(load_pc), .load_addr(load_addr),
        .addr_sel(addr_sel), .cond(cond), .sximm8(sximm8), .n_flag(N), .v_flag(V),
        .z_flag(Z), .c_out(out), .mem_addr(mem_addr)
    );

endmodule

`default_nettype wire

//--- rtl/program_counter.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_consts.svh"

module program_counter
    import isa_pkg::*;
(
    input  wire        clk,
    input  wire        rst_n,
    input  wire        load_pc,
    input  wire        load_addr,
    input  wire        addr_sel,
    input  wire cond_e cond,
    input  wire word_t sximm8,
    input  wire        n_flag,
    input  wire        v_flag,
    input  wire        z_flag,
    input  wire word_t c_out,
    output addr_t      mem_addr
);

    addr_t pc;
    addr_t next_pc;
    addr_t data_addr;
    logic  taken;

    always_comb begin
        case (cond)
            COND_AL: taken = 1'b1;
            COND_EQ: taken = z_flag;
            COND_NE: taken = !z_flag;
            COND_LT: taken = (n_flag != v_flag);
            COND_LE: taken = (n_flag != v_flag) || z_flag;
            default: taken = 1'b0; // non-branches and spare codes never jump.
        endcase
    end

    // Outside fetch the PC already points past the branch, so only the offset is added.
    always_comb begin
        if (addr_sel) begin
            next_pc = pc + 1'b1;
        end else if (taken) begin
            next_pc = pc + sximm8[`CPU_ADDR_W-1:0];
        end else begin
            next_pc = pc;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (load_pc) begin
            pc <= next_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (load_addr) begin
            data_addr <= c_out[`CPU_ADDR_W-1:0];
        end
    end

    assign mem_addr = addr_sel ? pc : data_addr;

    a_branch_only: assert property (@(posedge clk) disable iff (!rst_n)
        load_pc && !addr_sel |-> cond != COND_NONE);

endmodule

`default_nettype wire

//--- rtl/datapath.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_consts.svh"

module datapath
    import isa_pkg::*, ctrl_pkg::*;
(
    input  wire           clk,
    input  wire           rst_n,
    input  wire word_t    mdata,
    input  wire word_t    sximm5,
    input  wire word_t    sximm8,
    input  wire reg_idx_t reg_num,
    input  wire           write,
    input  wire wb_sel_e  wb_sel,
    input  wire           load_a,
    input  wire           load_b,
    input  wire           load_c,
    input  wire           load_s,
    input  wire           asel,
    input  wire           bsel,
    input  wire shift_e   shift,
    input  wire alu_op_e  alu_op,
    output word_t         c_out,
    output logic          n_flag,
    output logic          v_flag,
    output logic          z_flag
);

    localparam int MSB = `CPU_WORD_W - 1;

    word_t regs [`CPU_REG_COUNT];
    word_t wb_data;
    word_t rd_data;
    word_t a_reg;
    word_t b_reg;
    word_t b_shift;
    word_t ain;
    word_t bin;
    word_t alu_out;
    word_t diff;
    logic  sub_v;

    always_comb begin
        case (wb_sel)
            WB_IMM8:  wb_data = sximm8;
            WB_MDATA: wb_data = mdata;
            default:  wb_data = c_out;
        endcase
    end

    always_ff @(posedge clk) begin
        if (write) begin
            regs[reg_num] <= wb_data;
        end
    end

    assign rd_data = regs[reg_num]; // one field addresses both read and write.

    always_ff @(posedge clk) begin
        if (load_a) begin
            a_reg <= rd_data;
        end
        if (load_b) begin
            b_reg <= rd_data;
        end
    end

    always_comb begin
        case (shift)
            SH_LSL1: b_shift = {b_reg[MSB-1:0], 1'b0};
            SH_LSR1: b_shift = {1'b0, b_reg[MSB:1]};
            SH_ASR1: b_shift = {b_reg[MSB], b_reg[MSB:1]}; // keeps the sign.
            default: b_shift = b_reg;
        endcase
    end

    assign ain = asel ? '0 : a_reg;
    assign bin = bsel ? sximm5 : b_shift;

    assign diff  = ain - bin;
    assign sub_v = (ain[MSB] != bin[MSB]) && (diff[MSB] != ain[MSB]);

    always_comb begin
        case (alu_op)
            ALU_ADD: alu_out = ain + bin;
            ALU_CMP: alu_out = diff;
            ALU_AND: alu_out = ain & bin;
            default: alu_out = ~bin;
        endcase
    end

    always_ff @(posedge clk) begin
        if (load_c) begin
            c_out <= alu_out;
        end
    end

    // Status only changes on the last step of CMP.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            n_flag <= 1'b0;
            v_flag <= 1'b0;
            z_flag <= 1'b0;
        end else if (load_s) begin
            n_flag <= alu_out[MSB];
            v_flag <= sub_v;
            z_flag <= (alu_out == '0);
        end
    end

    a_wb_known: assert property (@(posedge clk) disable iff (!rst_n)
        write |-> !$isunknown(wb_data) && !$isunknown(reg_num));

endmodule

`default_nettype wire

//--- rtl/control_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module control_fsm
    import isa_pkg::*, ctrl_pkg::*;
(
    input  wire           clk,
    input  wire           rst_n,
    input  wire opcode_e  opcode,
    input  wire [1:0]     op,
    output logic          write,
    output logic          load_a,
    output logic          load_b,
    output logic          load_c,
    output logic          load_s,
    output logic          asel,
    output logic          bsel,
    output wb_sel_e       wb_sel,
    output reg_sel_e      reg_sel,
    output logic          load_ir,
    output logic          load_pc,
    output logic          load_addr,
    output logic          addr_sel,
    output mem_cmd_e      mem_cmd,
    output logic          halt
);

    state_e state;
    state_e next_state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IF1;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = HALTED; // undefined encodings end up here.
        case (state)
            IF1:       next_state = IF2;
            IF2:       next_state = UPDATE_PC;
            UPDATE_PC: next_state = DECODE;
            DECODE: begin
                case (opcode)
                    OPC_MOV: begin
                        if (op == MOV_IMM) begin
                            next_state = WRITE_IMM;
                        end else if (op == MOV_REG) begin
                            next_state = MOV_1;
                        end
                    end
                    OPC_ALU: begin
                        case (alu_op_e'(op))
                            ALU_ADD, ALU_AND: next_state = ALU_1;
                            ALU_CMP:          next_state = CMP_1;
                            default:          next_state = MVN_1;
                        endcase
                    end
                    OPC_LDR:    next_state = (op == 2'b00) ? LDR_1 : HALTED;
                    OPC_STR:    next_state = (op == 2'b00) ? STR_1 : HALTED;
                    OPC_BRANCH: next_state = (op == 2'b00) ? BR_1 : HALTED;
                    default:    next_state = HALTED;
                endcase
            end
            MOV_1: next_state = MOV_2;
            MOV_2: next_state = MOV_3;
            ALU_1: next_state = ALU_2;
            ALU_2: next_state = ALU_3;
            ALU_3: next_state = ALU_4;
            CMP_1: next_state = CMP_2;
            CMP_2: next_state = CMP_3;
            MVN_1: next_state = MVN_2;
            MVN_2: next_state = MVN_3;
            LDR_1: next_state = LDR_2;
            LDR_2: next_state = LDR_3;
            LDR_3: next_state = LDR_4;
            LDR_4: next_state = LDR_5;
            LDR_5: next_state = LDR_6;
            STR_1: next_state = STR_2;
            STR_2: next_state = STR_3;
            STR_3: next_state = STR_4;
            STR_4: next_state = STR_5;
            STR_5: next_state = STR_6;
            STR_6: next_state = STR_7;
            BR_1:  next_state = BR_2;
            WRITE_IMM, MOV_3, ALU_4, CMP_3, MVN_3, LDR_6, STR_7, BR_2: next_state = IF1;
            default: next_state = HALTED;
        endcase
    end

    always_comb begin
        write     = 1'b0;
        load_a    = 1'b0;
        load_b    = 1'b0;
        load_c    = 1'b0;
        load_s    = 1'b0;
        asel      = 1'b0;
        bsel      = 1'b0;
        wb_sel    = WB_C;
        reg_sel   = SEL_NONE;
        load_ir   = 1'b0;
        load_pc   = 1'b0;
        load_addr = 1'b0;
        addr_sel  = 1'b0;
        mem_cmd   = MEM_NONE;
        halt      = 1'b0;
        case (state)
            IF1: addr_sel = 1'b1; // the PC is presented before the read.
            IF2: begin
                addr_sel = 1'b1;
                mem_cmd  = MEM_READ;
            end
            UPDATE_PC: begin
                addr_sel = 1'b1; // marks the fetch step, so the PC only increments.
                load_ir  = 1'b1;
                load_pc  = 1'b1;
            end
            WRITE_IMM: begin
                write   = 1'b1;
                wb_sel  = WB_IMM8;
                reg_sel = SEL_RN;
            end
            MOV_1, ALU_1, CMP_1, MVN_1, STR_4: begin
                load_b  = 1'b1;
                reg_sel = (state == STR_4) ? SEL_RD : SEL_RM;
            end
            ALU_2, CMP_2, LDR_1, STR_1: begin
                load_a  = 1'b1;
                reg_sel = SEL_RN;
            end
            MOV_2, MVN_2, STR_5: begin
                asel   = 1'b1; // zero plus shifted B passes B through the ALU.
                load_c = 1'b1;
            end
            ALU_3: load_c = 1'b1;
            CMP_3: load_s = 1'b1;
            LDR_2, STR_2: begin
                bsel   = 1'b1; // Rn plus imm5 forms the data address.
                load_c = 1'b1;
            end
            LDR_3, STR_3: load_addr = 1'b1;
            LDR_5: mem_cmd = MEM_READ;
            MOV_3, ALU_4, MVN_3, LDR_6: begin
                write   = 1'b1;
                wb_sel  = (state == LDR_6) ? WB_MDATA : WB_C;
                reg_sel = SEL_RD;
            end
            STR_6: mem_cmd = MEM_WRITE;
            BR_2:  load_pc = 1'b1;
            HALTED: halt = 1'b1;
            default: ;
        endcase
    end

    a_halt_holds: assert property (@(posedge clk) disable iff (!rst_n)
        halt |=> halt && mem_cmd == MEM_NONE);

    // A store always follows the capture of its address three cycles earlier.
    a_store_addr: assert property (@(posedge clk) disable iff (!rst_n)
        mem_cmd == MEM_WRITE |-> !addr_sel && $past(load_addr, 3));

endmodule

`default_nettype wire

//--- rtl/inst_decoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_consts.svh"

module inst_decoder
    import isa_pkg::*, ctrl_pkg::*;
(
    input  wire           clk,
    input  wire           rst_n,
    input  wire word_t    in,
    input  wire           load_ir,
    input  wire reg_sel_e reg_sel,
    output opcode_e       opcode,
    output logic [1:0]    op,
    output alu_op_e       alu_op,
    output shift_e        shift,
    output cond_e         cond,
    output reg_idx_t      reg_num,
    output word_t         sximm5,
    output word_t         sximm8
);

    word_t ir;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ir <= '0;
        end else if (load_ir) begin
            ir <= in; // the fetched word becomes the current instruction.
        end
    end

    assign opcode = opcode_e'(ir[15:13]);
    assign op     = ir[12:11];
    assign alu_op = alu_op_e'(ir[12:11]);
    assign sximm5 = {{(`CPU_WORD_W-`CPU_IMM5_W){ir[`CPU_IMM5_W-1]}}, ir[`CPU_IMM5_W-1:0]};
    assign sximm8 = {{(`CPU_WORD_W-`CPU_IMM8_W){ir[`CPU_IMM8_W-1]}}, ir[`CPU_IMM8_W-1:0]};

    // Only branches carry a condition, everything else just steps the PC.
    assign cond = (opcode == OPC_BRANCH) ? cond_e'(ir[10:8]) : COND_NONE;

    always_comb begin
        case (reg_sel)
            SEL_RN:   reg_num = ir[10:8];
            SEL_RD:   reg_num = ir[7:5];
            SEL_RM:   reg_num = ir[2:0];
            default:  reg_num = '0;
        endcase
    end

    always_comb begin
        if (opcode == OPC_MOV || opcode == OPC_ALU) begin
            shift = shift_e'(ir[4:3]);
        end else begin
            shift = SH_NONE; // bits 4..3 belong to imm5 in LDR and STR.
        end
    end

    // A register access is only requested once a fetched instruction is in the IR.
    a_reg_num_known: assert property (@(posedge clk) disable iff (!rst_n)
        reg_sel != SEL_NONE |-> !$isunknown(reg_num));

endmodule

`default_nettype wire

//--- rtl/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

    typedef enum logic [5:0] {
        IF1, IF2, UPDATE_PC, DECODE,
        WRITE_IMM,
        MOV_1, MOV_2, MOV_3,
        ALU_1, ALU_2, ALU_3, ALU_4,
        CMP_1, CMP_2, CMP_3,
        MVN_1, MVN_2, MVN_3,
        LDR_1, LDR_2, LDR_3, LDR_4, LDR_5, LDR_6,
        STR_1, STR_2, STR_3, STR_4, STR_5, STR_6, STR_7,
        BR_1, BR_2,
        HALTED
    } state_e;

    typedef enum logic [1:0] {
        MEM_NONE  = 2'b00,
        MEM_WRITE = 2'b01,
        MEM_READ  = 2'b10
    } mem_cmd_e;

    typedef enum logic [1:0] {
        WB_C,     // result of the ALU held in C.
        WB_IMM8,  // sign-extended immediate of MOV.
        WB_MDATA  // word returned by memory for LDR.
    } wb_sel_e;

    // Picks which instruction field addresses the register file.
    typedef enum logic [1:0] {
        SEL_NONE, SEL_RN, SEL_RD, SEL_RM
    } reg_sel_e;

endpackage

`default_nettype wire

//--- rtl/isa_pkg.sv
`default_nettype none

`include "cpu_consts.svh"

package isa_pkg;

    typedef logic [`CPU_WORD_W-1:0]    word_t;
    typedef logic [`CPU_ADDR_W-1:0]    addr_t;
    typedef logic [`CPU_REG_IDX_W-1:0] reg_idx_t;

    // Major opcode in bits 15..13. Codes 000 and 010 are undefined and halt.
    typedef enum logic [2:0] {
        OPC_BRANCH = 3'b001,
        OPC_LDR    = 3'b011,
        OPC_STR    = 3'b100,
        OPC_ALU    = 3'b101,
        OPC_MOV    = 3'b110,
        OPC_HALT   = 3'b111
    } opcode_e;

    typedef enum logic [1:0] {
        MOV_REG = 2'b00, // move a shifted register.
        MOV_IMM = 2'b10  // move a sign-extended imm8.
    } mov_op_e;

    typedef enum logic [1:0] {
        ALU_ADD = 2'b00,
        ALU_CMP = 2'b01, // subtracts and only updates the status flags.
        ALU_AND = 2'b10,
        ALU_MVN = 2'b11
    } alu_op_e;

    typedef enum logic [1:0] {
        SH_NONE = 2'b00,
        SH_LSL1 = 2'b01,
        SH_LSR1 = 2'b10,
        SH_ASR1 = 2'b11
    } shift_e;

    typedef enum logic [2:0] {
        COND_AL   = 3'b000,
        COND_EQ   = 3'b001,
        COND_NE   = 3'b010,
        COND_LT   = 3'b011,
        COND_LE   = 3'b100,
        COND_NONE = 3'b111 // given to every non-branch instruction.
    } cond_e;

endpackage

`default_nettype wire

//--- rtl/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Width of a data word and of an instruction.
`define CPU_WORD_W 16

// Memory is addressed by words, so 512 words in all.
`define CPU_ADDR_W 9

// General register file.
`define CPU_REG_COUNT 8
`define CPU_REG_IDX_W 3

// Offset field of LDR and STR.
`define CPU_IMM5_W 5

// Immediate of MOV and offset of a branch.
`define CPU_IMM8_W 8

`endif
